//--- design/mips_pkg.sv
// sizes are fixed by the isa and the apb address map; only the listed opcodes and functs exist
package mips_pkg;

  localparam int data_width      = 32;  // registers, memory words, apb data
  localparam int reg_addr_width  = 5;   // 32 registers
  localparam int dmem_words      = 16;  // data memory depth
  localparam int dmem_addr_width = 4;   // word index into data memory
  localparam int apb_addr_width  = 12;  // apb byte address

  // apb address map, byte addresses
  localparam logic [apb_addr_width-1:0] addr_issue     = 12'h000;  // write only, instruction
  localparam logic [apb_addr_width-1:0] addr_v0        = 12'h004;  // read only, register 2
  localparam logic [apb_addr_width-1:0] addr_reg_base  = 12'h080;  // 32 words, read only
  localparam logic [apb_addr_width-1:0] addr_dmem_base = 12'h100;  // 16 words, read/write

  typedef enum logic [5:0] {
    op_special = 6'h00,  // r-type, funct selects the operation
    op_addiu   = 6'h09,
    op_ori     = 6'h0d,
    op_lui     = 6'h0f,
    op_lwl     = 6'h22,
    op_lw      = 6'h23,
    op_lwr     = 6'h26,
    op_sw      = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    fn_addu = 6'h21,
    fn_subu = 6'h23,
    fn_and  = 6'h24,
    fn_or   = 6'h25
  } funct_e;

  typedef enum logic [2:0] {
    alu_add,  // also used for load/store address
    alu_sub,
    alu_and,
    alu_or,
    alu_lui   // immediate into the upper half
  } alu_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_execute,
    st_mem,       // loads only
    st_writeback
  } seq_state_e;

endpackage

//--- design/apb_host_port.sv
// apb slave, word aligned accesses only; an issue write stalls with pready low until done
module apb_host_port
  import mips_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  logic [apb_addr_width-1:0]  paddr,
  input  logic [data_width-1:0]      pwdata,
  input  logic                       done,            // instruction finished, from sequencer
  input  logic                       illegal,         // from control, decoded from instr
  input  logic [data_width-1:0]      rd_data_a,       // register file port a
  input  logic [data_width-1:0]      v0,
  input  logic [data_width-1:0]      dmem_rdata,
  output logic [data_width-1:0]      prdata,
  output logic                       pready,
  output logic                       pslverr,
  output logic [data_width-1:0]      instr,
  output logic                       start,
  output logic [reg_addr_width-1:0]  read_reg_a,
  output logic                       host_dmem_we,
  output logic [dmem_addr_width-1:0] host_dmem_addr,
  output logic [data_width-1:0]      host_dmem_wdata
);

  logic                  setup, access;  // apb phases
  logic                  aligned;
  logic                  issue_hit, v0_hit, reg_hit, dmem_hit;
  logic                  issue_setup;    // setup cycle of an instruction write
  logic                  err;
  logic                  err_q;          // error decided in setup, reported in access
  logic                  busy_q;         // instruction in flight
  logic [data_width-1:0] instr_q;

  assign setup   = psel & ~penable;
  assign access  = psel & penable;
  assign aligned = (paddr[1:0] == 2'b00);

  assign issue_hit = (paddr == addr_issue);
  assign v0_hit    = (paddr == addr_v0);
  assign reg_hit   = aligned & (paddr[11:7] == addr_reg_base[11:7]);   // 0x080..0x0ff
  assign dmem_hit  = aligned & (paddr[11:6] == addr_dmem_base[11:6]);  // 0x100..0x13f

  assign issue_setup = setup & pwrite & issue_hit;
  // control decodes pwdata directly during the issue setup cycle
  assign instr = issue_setup ? pwdata : instr_q;
  assign start = issue_setup & ~illegal;

  // unmapped, write to read only, read of write only, or bad instruction
  assign err = ~(issue_hit | v0_hit | reg_hit | dmem_hit)
             | (pwrite & (v0_hit | reg_hit))
             | (~pwrite & issue_hit)
             | (issue_setup & illegal);

  always_ff @(posedge clk) begin
    if (reset) begin
      err_q  <= 1'b0;
      busy_q <= 1'b0;
    end else begin
      if (setup) err_q <= err;  // paddr stays stable through access
      if (start) busy_q <= 1'b1;
      else if (done) busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start) instr_q <= pwdata;  // illegal words are never held
  end

  assign pready  = access & (busy_q ? done : 1'b1);  // plain accesses finish in one access cycle
  assign pslverr = pready & err_q;

  assign read_reg_a = busy_q ? instr[25:21] : paddr[6:2];  // rs while executing

  assign host_dmem_we    = access & pwrite & dmem_hit;
  assign host_dmem_addr  = paddr[5:2];  // read launched in setup, data ready in access
  assign host_dmem_wdata = pwdata;

  always_comb begin
    if (dmem_hit) prdata = dmem_rdata;
    else if (v0_hit) prdata = v0;
    else if (reg_hit) prdata = rd_data_a;
    else prdata = '0;
  end

endmodule

//--- design/exec_sequencer.sv
// one instruction at a time; start is ignored unless idle
module exec_sequencer
  import mips_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,         // pulse from the host port
  input  logic       is_load,       // adds the memory read cycle
  output seq_state_e state,
  output logic       clk_enable,    // register file write strobe
  output logic       mem_we_phase,  // cycle in which sw writes memory
  output logic       done
);

  seq_state_e next_state;

  always_comb begin
    next_state = state;
    case (state)
      st_idle:      if (start) next_state = st_execute;
      st_execute:   next_state = is_load ? st_mem : st_writeback;
      st_mem:       next_state = st_writeback;  // sync ram read lands here
      st_writeback: next_state = st_idle;
      default:      next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      done  <= 1'b0;
    end else begin
      state <= next_state;
      done  <= (state == st_writeback);  // one cycle after the write lands
    end
  end

  assign clk_enable   = (state == st_writeback);
  assign mem_we_phase = (state == st_writeback);

endmodule

//--- design/control.sv
// decodes only the supported subset; every other opcode or funct raises illegal
module control
  import mips_pkg::*;
(
  input  logic [data_width-1:0] instr,
  output logic                  reg_write_enable,
  output logic                  dst_is_rd,       // r-type writes rd, the rest write rt
  output logic                  wdata_from_mem,  // register gets memory word
  output logic                  lwl,
  output logic                  lwr,
  output logic                  mem_write,
  output logic                  is_load,
  output logic                  imm_zero_ext,    // ori zero extends
  output alu_op_e               alu_op,
  output logic                  illegal
);

  opcode_e opcode;
  funct_e  funct;

  assign opcode = opcode_e'(instr[31:26]);
  assign funct  = funct_e'(instr[5:0]);

  always_comb begin
    reg_write_enable = 1'b0;
    dst_is_rd        = 1'b0;
    wdata_from_mem   = 1'b0;
    lwl              = 1'b0;
    lwr              = 1'b0;
    mem_write        = 1'b0;
    is_load          = 1'b0;
    imm_zero_ext     = 1'b0;
    alu_op           = alu_add;
    illegal          = 1'b0;
    case (opcode)
      op_special: begin
        reg_write_enable = 1'b1;
        dst_is_rd        = 1'b1;
        case (funct)
          fn_addu: alu_op = alu_add;
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          default: begin
            reg_write_enable = 1'b0;
            illegal          = 1'b1;
          end
        endcase
      end
      op_addiu: reg_write_enable = 1'b1;
      op_ori: begin
        reg_write_enable = 1'b1;
        imm_zero_ext     = 1'b1;
        alu_op           = alu_or;
      end
      op_lui: begin
        reg_write_enable = 1'b1;
        alu_op           = alu_lui;
      end
      op_lw, op_lwl, op_lwr: begin
        reg_write_enable = 1'b1;
        wdata_from_mem   = 1'b1;
        is_load          = 1'b1;
        lwl              = (opcode == op_lwl);
        lwr              = (opcode == op_lwr);
      end
      op_sw:   mem_write = 1'b1;  // address from alu_add
      default: illegal = 1'b1;
    endcase
  end

endmodule

//--- design/alu.sv
// result is registered on capture and holds through mem and writeback
module alu
  import mips_pkg::*;
(
  input  logic                  clk,
  input  logic [data_width-1:0] a,             // rs
  input  logic [data_width-1:0] b,             // rt
  input  logic [15:0]           imm,
  input  logic                  imm_zero_ext,
  input  logic                  use_imm,       // i-type, immediate replaces rt
  input  alu_op_e               alu_op,
  input  logic                  capture,       // high in st_execute
  output logic [data_width-1:0] result
);

  logic [data_width-1:0] imm_ext;
  logic [data_width-1:0] operand_b;
  logic [data_width-1:0] result_d;

  assign imm_ext   = imm_zero_ext ? {16'h0000, imm} : {{16{imm[15]}}, imm};
  assign operand_b = use_imm ? imm_ext : b;

  always_comb begin
    case (alu_op)
      alu_add: result_d = a + operand_b;  // also load/store address
      alu_sub: result_d = a - operand_b;
      alu_and: result_d = a & operand_b;
      alu_or:  result_d = a | operand_b;
      alu_lui: result_d = {imm, 16'h0000};
      default: result_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (capture) result <= result_d;
  end

endmodule

//--- design/data_memory.sv
// contents are undefined after power up; read data appears one cycle after the address
module data_memory
  import mips_pkg::*;
(
  input  logic                       clk,
  input  logic                       we,
  input  logic [dmem_addr_width-1:0] addr,   // word address
  input  logic [data_width-1:0]      wdata,
  output logic [data_width-1:0]      rdata
);

  logic [data_width-1:0] mem [dmem_words];

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= wdata;
    rdata <= mem[addr];  // read before write on the same word
  end

endmodule

//--- design/register_file.sv
// reads are combinational; writes land on the clock edge where clk_enable is high
module register_file
  import mips_pkg::*;
(
  input  logic                      clk,
  input  logic                      clk_enable,        // high only in writeback
  input  logic                      reset,
  input  logic [reg_addr_width-1:0] read_reg_a,        // rs or host index
  input  logic [reg_addr_width-1:0] read_reg_b,        // rt
  input  logic [reg_addr_width-1:0] write_reg_rd,      // destination
  input  logic                      reg_write_enable,
  input  logic [data_width-1:0]     reg_write_data,
  input  logic [1:0]                byte_addressing,   // low address bits for lwl/lwr
  input  logic                      lwl,
  input  logic                      lwr,
  output logic [data_width-1:0]     read_data_a,
  output logic [data_width-1:0]     read_data_b,
  output logic [data_width-1:0]     register_v0
);

  logic [data_width-1:0] regs [1:31];  // register 0 has no storage
  logic [data_width-1:0] merged;       // value written to the destination
  logic                  write_now;

  assign read_data_a = (read_reg_a == '0) ? '0 : regs[read_reg_a];
  assign read_data_b = (read_reg_b == '0) ? '0 : regs[read_reg_b];
  assign register_v0 = regs[2];

  assign write_now = clk_enable & reg_write_enable & (write_reg_rd != '0);

  // lwl fills from the top down, lwr from the bottom up
  always_comb begin
    merged = (write_reg_rd == '0) ? '0 : regs[write_reg_rd];
    if (lwl) begin
      case (byte_addressing)
        2'd0: merged[31:24] = reg_write_data[7:0];
        2'd1: merged[31:16] = reg_write_data[15:0];
        2'd2: merged[31:8]  = reg_write_data[23:0];
        2'd3: merged        = reg_write_data;
        default: merged    = reg_write_data;
      endcase
    end else if (lwr) begin
      case (byte_addressing)
        2'd0: merged        = reg_write_data;
        2'd1: merged[23:0]  = reg_write_data[31:8];
        2'd2: merged[15:0]  = reg_write_data[31:16];
        2'd3: merged[7:0]   = reg_write_data[31:24];
        default: merged    = reg_write_data;
      endcase
    end else begin
      merged = reg_write_data;  // plain write replaces the whole word
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (write_now) begin
      regs[write_reg_rd] <= merged;
    end
  end

endmodule

//--- design/mips_exec_top.sv
// single issue core behind apb; no fetch, no branches, no byte or halfword stores
module mips_exec_top
  import mips_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [apb_addr_width-1:0] paddr,
  input  logic [data_width-1:0]     pwdata,
  output logic [data_width-1:0]     prdata,
  output logic                      pready,
  output logic                      pslverr
);

  logic [data_width-1:0]      instr, rd_data_a, rd_data_b, v0, alu_result, dmem_rdata;
  logic [data_width-1:0]      host_dmem_wdata, reg_write_data, dmem_wdata;
  logic [reg_addr_width-1:0]  read_reg_a, write_reg_rd;
  logic [dmem_addr_width-1:0] host_dmem_addr, dmem_addr;
  logic                       start, done, illegal, host_dmem_we, dmem_we;
  logic                       clk_enable, mem_we_phase, seq_idle;
  logic                       reg_write_enable, dst_is_rd, wdata_from_mem, lwl, lwr;
  logic                       mem_write, is_load, imm_zero_ext;
  alu_op_e                    alu_op;
  seq_state_e                 state;

  apb_host_port u_host (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .done, .illegal,
    .rd_data_a, .v0, .dmem_rdata, .prdata, .pready, .pslverr, .instr, .start,
    .read_reg_a, .host_dmem_we, .host_dmem_addr, .host_dmem_wdata
  );

  exec_sequencer u_seq (.clk, .reset, .start, .is_load, .state, .clk_enable, .mem_we_phase, .done);

  control u_ctrl (
    .instr, .reg_write_enable, .dst_is_rd, .wdata_from_mem, .lwl, .lwr,
    .mem_write, .is_load, .imm_zero_ext, .alu_op, .illegal
  );

  alu u_alu (
    .clk, .a(rd_data_a), .b(rd_data_b), .imm(instr[15:0]), .imm_zero_ext,
    .use_imm(~dst_is_rd), .alu_op, .capture(state == st_execute), .result(alu_result)
  );

  assign write_reg_rd   = dst_is_rd ? instr[15:11] : instr[20:16];  // rd for special
  assign reg_write_data = wdata_from_mem ? dmem_rdata : alu_result;

  // host owns the memory port only while nothing executes
  assign seq_idle   = (state == st_idle);
  assign dmem_we    = seq_idle ? host_dmem_we : (mem_write & mem_we_phase);
  assign dmem_addr  = seq_idle ? host_dmem_addr : alu_result[5:2];
  assign dmem_wdata = seq_idle ? host_dmem_wdata : rd_data_b;  // sw stores rt

  data_memory u_dmem (.clk, .we(dmem_we), .addr(dmem_addr), .wdata(dmem_wdata), .rdata(dmem_rdata));

  register_file u_rf (
    .clk, .clk_enable, .reset, .read_reg_a, .read_reg_b(instr[20:16]), .write_reg_rd,
    .reg_write_enable, .reg_write_data, .byte_addressing(alu_result[1:0]), .lwl, .lwr,
    .read_data_a(rd_data_a), .read_data_b(rd_data_b), .register_v0(v0)
  );

endmodule

//--- dv/tb_mips_exec.sv
// the host fills every memory word before any load reads it; random operands use registers 0..7
module tb_mips_exec
  import mips_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int max_cycles = 4000;  // about 1300 cycles of tests with 3x margin

  logic                      clk, reset, psel, penable, pwrite, pready, pslverr;
  logic [apb_addr_width-1:0] paddr;
  logic [data_width-1:0]     pwdata, prdata;
  logic [data_width-1:0]     model_regs [32];          // reference register file
  logic [data_width-1:0]     model_mem [dmem_words];   // reference data memory
  int                        error_count = 0;
  int                        check_count = 0;
  int                        cycle_count = 0;
  integer                    seed = 13;

  mips_exec_top DUT (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin : watchdog
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", max_cycles);
    $display("tests failed");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected) else begin
      $display("** Error at %0d ns: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  // setup cycle, then access cycles until pready; outputs sampled on the falling edge
  task automatic apb_transfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);  // issue stalls here until done
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata, output logic err);
    logic [31:0] ignored;
    apb_transfer(1'b1, addr, wdata, ignored, err);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] rdata, output logic err);
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
  endtask

  function automatic logic [31:0] r_instr(input logic [4:0] rs, rt, rd, input funct_e fn);
    return {op_special, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] i_instr(input opcode_e op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // lwl at offset k moves the low k+1 data bytes to the top of the register
  function automatic logic [31:0] merge_left(input logic [31:0] old, data, input int k);
    int sh;
    sh = 8 * (3 - k);
    return (data << sh) | (old & ((32'h1 << sh) - 32'h1));
  endfunction

  // lwr at offset k moves the top 4-k data bytes to the bottom of the register
  function automatic logic [31:0] merge_right(input logic [31:0] old, data, input int k);
    int sh;
    sh = 8 * k;
    return (data >> sh) | (old & ~(32'hffff_ffff >> sh));
  endfunction

  task automatic set_reg(input logic [4:0] idx, input logic [31:0] value);
    if (idx != '0) model_regs[idx] = value;  // r0 stays zero
  endtask

  task automatic apply_model(input logic [31:0] instr);
    logic [31:0] a, b, sext, addr;
    int          w;
    a    = model_regs[instr[25:21]];
    b    = model_regs[instr[20:16]];
    sext = {{16{instr[15]}}, instr[15:0]};
    addr = a + sext;  // load/store byte address
    w    = int'(addr[5:2]);
    case (instr[31:26])
      op_special: begin
        case (instr[5:0])
          fn_addu: set_reg(instr[15:11], a + b);
          fn_subu: set_reg(instr[15:11], a - b);
          fn_and:  set_reg(instr[15:11], a & b);
          fn_or:   set_reg(instr[15:11], a | b);
          default: ;
        endcase
      end
      op_addiu: set_reg(instr[20:16], a + sext);
      op_ori:   set_reg(instr[20:16], a | {16'h0, instr[15:0]});
      op_lui:   set_reg(instr[20:16], {instr[15:0], 16'h0});
      op_lw:    set_reg(instr[20:16], model_mem[w]);
      op_lwl:   set_reg(instr[20:16], merge_left(b, model_mem[w], int'(addr[1:0])));
      op_lwr:   set_reg(instr[20:16], merge_right(b, model_mem[w], int'(addr[1:0])));
      op_sw:    model_mem[w] = b;
      default:  ;
    endcase
  endtask

  task automatic check_reg(input int idx);
    logic [31:0] data;
    logic        err;
    apb_read(addr_reg_base + 12'(idx * 4), data, err);
    check_value($sformatf("r%0d", idx), model_regs[idx], data);
    check_value("pslverr", 32'h0, 32'(err));
  endtask

  task automatic check_v0();
    logic [31:0] data;
    logic        err;
    apb_read(addr_v0, data, err);
    check_value("v0", model_regs[2], data);
  endtask

  task automatic check_mem(input int w);
    logic [31:0] data;
    logic        err;
    apb_read(addr_dmem_base + 12'(w * 4), data, err);
    check_value($sformatf("mem[%0d]", w), model_mem[w], data);
  endtask

  task automatic check_regs();
    for (int i = 0; i < 32; i++) check_reg(i);
    check_v0();
  endtask

  task automatic check_mems();
    for (int w = 0; w < dmem_words; w++) check_mem(w);
  endtask

  // issue one instruction, then read back its destination and v0
  task automatic run_instr(input logic [31:0] instr, input logic expect_err);
    logic err;
    apb_write(addr_issue, instr, err);
    check_value("pslverr", 32'(expect_err), 32'(err));
    if (!expect_err) apply_model(instr);
    check_reg(int'((instr[31:26] == op_special) ? instr[15:11] : instr[20:16]));
    check_v0();
  endtask

  task automatic load_pattern(input logic [4:0] idx, input logic [31:0] value);
    run_instr(i_instr(op_lui, 0, idx, value[31:16]), 1'b0);
    run_instr(i_instr(op_ori, idx, idx, value[15:0]), 1'b0);
  endtask

  task automatic arith_test();
    logic [31:0] r;
    logic [4:0]  rs, rt, rd;
    run_instr(i_instr(op_addiu, 0, 0, 16'h7fff), 1'b0);  // r0 must stay zero
    repeat (30) begin
      r  = $random(seed);
      rs = {2'b00, r[5:3]};
      rt = {2'b00, r[8:6]};
      rd = {2'b00, r[11:9]};
      case (r[2:0])
        3'd0: run_instr(i_instr(op_addiu, rs, rt, r[31:16]), 1'b0);
        3'd1: run_instr(i_instr(op_ori, rs, rt, r[31:16]), 1'b0);
        3'd2: run_instr(i_instr(op_lui, rs, rt, r[31:16]), 1'b0);
        3'd3: run_instr(r_instr(rs, rt, rd, fn_addu), 1'b0);
        3'd4: run_instr(r_instr(rs, rt, rd, fn_subu), 1'b0);
        3'd5: run_instr(r_instr(rs, rt, rd, fn_and), 1'b0);
        default: run_instr(r_instr(rs, rt, rd, fn_or), 1'b0);
      endcase
    end
    check_regs();
  endtask

  task automatic mem_test();
    logic err;
    for (int w = 0; w < dmem_words; w++) begin
      model_mem[w] = 32'h5a3c_96e1 ^ (32'h0101_0101 * (w + 1));  // differs per word
      apb_write(addr_dmem_base + 12'(w * 4), model_mem[w], err);
    end
    check_mems();
    run_instr(i_instr(op_lw, 0, 4, 16'h0000), 1'b0);
    run_instr(i_instr(op_lw, 0, 5, 16'h0014), 1'b0);
    run_instr(i_instr(op_lw, 0, 2, 16'h003c), 1'b0);  // lands in v0
    load_pattern(6, 32'hcafe_f00d);
    run_instr(i_instr(op_sw, 0, 6, 16'h0020), 1'b0);
    check_mem(8);
  endtask

  task automatic merge_test();
    logic [31:0] data;
    logic        err;
    for (int k = 0; k < 4; k++) begin
      load_pattern(9, 32'h1122_3344);
      run_instr(i_instr(op_lwl, 0, 9, 16'(12 + k)), 1'b0);
      load_pattern(9, 32'h1122_3344);
      run_instr(i_instr(op_lwr, 0, 9, 16'(12 + k)), 1'b0);
    end
    load_pattern(10, 32'hdead_beef);
    run_instr(i_instr(op_lwr, 0, 10, 16'd12), 1'b0);
    run_instr(i_instr(op_lwl, 0, 10, 16'd15), 1'b0);
    apb_read(addr_reg_base + 12'd40, data, err);
    check_value("r10", model_mem[3], data);  // whole word rebuilt
  endtask

  task automatic error_test();
    logic [31:0] data;
    logic        err;
    run_instr(32'hfc00_0000, 1'b1);                            // opcode 0x3f
    run_instr({6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h20}, 1'b1);  // add is an unsupported funct
    apb_write(addr_v0, 32'hffff_ffff, err);
    check_value("pslverr", 32'h1, 32'(err));
    apb_read(12'h200, data, err);                              // unmapped
    check_value("pslverr", 32'h1, 32'(err));
    check_regs();
    check_mems();
  endtask

  initial begin
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    check_regs();  // everything reads zero after reset
    arith_test();
    mem_test();
    merge_test();
    error_test();
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) $display("all tests passed");
    else $display("tests failed");
    $finish;
  end

endmodule

//--- vlog.f
design/mips_pkg.sv
design/apb_host_port.sv
design/exec_sequencer.sv
design/control.sv
design/alu.sv
design/data_memory.sv
design/register_file.sv
design/mips_exec_top.sv
dv/tb_mips_exec.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mips_exec -f vlog.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -qx "all tests passed" sim.log; then
  echo "simulation result: PASS"
  exit 0
else
  echo "simulation result: FAIL"
  exit 1
fi
